// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module exec_tb \
  --Mdir obj_dir \
  -o exec_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/exec_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// ==== tb/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb;
  import rv_pkg::*;

  localparam int TIMEOUT = 50;

  typedef struct {
    logic [31:0] instr, pc, rs1, rs2, csr, trap, result, reg_wen;
    logic [31:0] jump, target, ren, wen, wmask, addr, exc, cause, csr_t;
  } row_t;

  logic        i_clock, i_reset, i_valid, i_ready, i_flush;
  logic [31:0] i_instr, i_pc, i_rs1_data, i_rs2_data, i_csr_data, i_trap_pc;
  logic        o_ready, o_valid, o_reg_wen, o_jump, o_redirect;
  logic        o_mem_ren, o_mem_wen, o_fencei, o_exception;
  logic [31:0] o_result, o_target, o_mem_addr, o_mem_wdata;
  logic [4:0]  o_rd;
  logic [3:0]  o_mem_wmask, o_mcause;
  logic [2:0]  o_mem_read_t;
  logic [1:0]  o_csr_t;
  logic [11:0] o_csr_addr;
  row_t        rows[$];
  logic [31:0] a, b, held_result, held_target, held_addr;

  tb_clock u_clock (.o_clock(i_clock), .o_reset(i_reset));

  exec_top i_dut (.*);

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    rv_instr_u w;
    w.r_fmt = '{f7, rs2, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    rv_instr_u w;
    w.i_fmt = '{imm, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
    rv_instr_u w;
    w.s_fmt = '{imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OP_STORE};
    return w;
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    rv_instr_u w;
    w.b_fmt = '{imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OP_BRANCH};
    return w;
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [6:0] op);
    rv_instr_u w;
    w.u_fmt = '{imm, 5'd4, op};
    return w;
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm);
    rv_instr_u w;
    w.j_fmt = '{imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OP_JAL};
    return w;
  endfunction

  task automatic add_row(input logic [31:0] instr, pc, rs1, rs2, result, reg_wen);
    row_t r;
    r = '{instr, pc, rs1, rs2, 32'h0, 32'h0, result, reg_wen, 32'h0, 32'h0,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
    rows.push_back(r);
  endtask

  task automatic set_jump(input logic [31:0] target);
    rows[rows.size()-1].jump   = 32'h1;
    rows[rows.size()-1].target = target;
  endtask

  task automatic set_mem(input logic [31:0] ren, wen, wmask, addr);
    rows[rows.size()-1].ren   = ren;
    rows[rows.size()-1].wen   = wen;
    rows[rows.size()-1].wmask = wmask;
    rows[rows.size()-1].addr  = addr;
  endtask

  task automatic set_trap(input logic [31:0] csr, trap, exc, cause, kind);
    rows[rows.size()-1].csr   = csr;
    rows[rows.size()-1].trap  = trap;
    rows[rows.size()-1].exc   = exc;
    rows[rows.size()-1].cause = cause;
    rows[rows.size()-1].csr_t = kind;
  endtask

  task automatic build_table;
    a = $urandom();
    b = $urandom();
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OP_REG), 32'h0, a, b, a + b, 32'h1);
    add_row(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OP_REG), 32'h0, a, b, a - b, 32'h1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3, OP_REG), 32'h0, a, b,
            ($signed(a) < $signed(b)) ? 32'h1 : 32'h0, 32'h1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd3, OP_REG), 32'h0, a, b,
            (a < b) ? 32'h1 : 32'h0, 32'h1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd3, OP_REG), 32'h0, a, b, a << b[4:0], 32'h1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd3, OP_REG), 32'h0, a, b, a >> b[4:0], 32'h1);
    add_row(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3, OP_REG), 32'h0, a, b,
            32'($signed(a) >>> b[4:0]), 32'h1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd3, OP_REG), 32'h0, a, b, a ^ b, 32'h1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd3, OP_REG), 32'h0, a, b, a | b, 32'h1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd3, OP_REG), 32'h0, a, b, a & b, 32'h1);
    add_row(enc_i(12'hffb, 5'd1, 3'd0, 5'd3, OP_IMM), 32'h0, a, b, a - 32'd5, 32'h1);
    add_row(enc_i(12'hff0, 5'd1, 3'd7, 5'd3, OP_IMM), 32'h0, a, b, a & 32'hfffffff0, 32'h1);
    add_row(enc_i({7'h20, 5'd7}, 5'd1, 3'd5, 5'd3, OP_IMM), 32'h0, a, b,
            32'($signed(a) >>> 7), 32'h1);
    add_row(enc_u(20'h12345, OP_LUI), 32'h0, a, b, 32'h12345000, 32'h1);
    add_row(enc_u(20'h00002, OP_AUIPC), 32'h1000, a, b, 32'h3000, 32'h1);
    add_row(enc_i(12'h010, 5'd1, 3'd2, 5'd5, OP_LOAD), 32'h0, 32'h2000, b, 32'h2010, 32'h1);
    set_mem(32'h1, 32'h0, 32'h0, 32'h2010);
    add_row(enc_s(12'h008, 3'd0), 32'h0, 32'h3000, b, 32'h0, 32'h0);
    set_mem(32'h0, 32'h1, 32'h1, 32'h3008);
    add_row(enc_s(12'hffc, 3'd1), 32'h0, 32'h3000, b, 32'h0, 32'h0);
    set_mem(32'h0, 32'h1, 32'h3, 32'h2ffc);
    add_row(enc_s(12'h00c, 3'd2), 32'h0, 32'h3000, b, 32'h0, 32'h0);
    set_mem(32'h0, 32'h1, 32'hf, 32'h300c);
    add_row(enc_b(13'h010, 3'd0), 32'h100, 32'h5, 32'h5, 32'h0, 32'h0);
    set_jump(32'h110);
    add_row(enc_b(13'h010, 3'd1), 32'h100, 32'h5, 32'h5, 32'h0, 32'h0);
    add_row(enc_b(13'h1ff8, 3'd4), 32'h200, 32'hffffffff, 32'h1, 32'h0, 32'h0);
    set_jump(32'h1f8);
    add_row(enc_b(13'h1ff8, 3'd6), 32'h200, 32'hffffffff, 32'h1, 32'h0, 32'h0);
    add_row(enc_b(13'h008, 3'd7), 32'h200, 32'hffffffff, 32'h1, 32'h0, 32'h0);
    set_jump(32'h208);
    add_row(enc_j(21'h000800), 32'h400, a, b, 32'h404, 32'h1);
    set_jump(32'hc00);
    add_row(enc_i(12'h004, 5'd1, 3'd0, 5'd1, OP_JALR), 32'h500, 32'h1001, b, 32'h504, 32'h1);
    set_jump(32'h1004); // Bit 0 of the sum is cleared
    add_row(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 7'h7f), 32'h0, a, b, 32'h0, 32'h0);
    set_trap(32'h0, 32'h0, 32'h1, 32'(CAUSE_ILLEGAL), 32'(CSR_NONE));
    add_row(enc_i(12'h000, 5'd0, 3'd0, 5'd0, OP_SYSTEM), 32'h600, a, b, 32'h0, 32'h0);
    set_trap(32'h0, 32'h80000100, 32'h1, 32'(CAUSE_ECALL), 32'(CSR_TRAP));
    set_jump(32'h80000100);
    add_row(enc_i(12'h300, 5'd0, 3'd2, 5'd5, OP_SYSTEM), 32'h0, a, b, 32'hcafe0001, 32'h1);
    set_trap(32'hcafe0001, 32'h0, 32'h0, 32'h0, 32'(CSR_WRITE));
  endtask

  task automatic check_value(input string name, input logic [31:0] got, exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("TB FAILED");
    $fatal(1, "Timeout");
  endtask

  task automatic issue_row(input int idx);
    int n;
    n = 0;
    @(negedge i_clock);
    i_valid    = 1'b1;
    i_instr    = rows[idx].instr;
    i_pc       = rows[idx].pc;
    i_rs1_data = rows[idx].rs1;
    i_rs2_data = rows[idx].rs2;
    i_csr_data = rows[idx].csr;
    i_trap_pc  = rows[idx].trap;
    #1;
    while (!o_ready) begin
      if (n == TIMEOUT) fail_timeout("o_ready to accept an instruction");
      n++;
      @(negedge i_clock);
      #1;
    end
    @(negedge i_clock);
    i_valid = 1'b0;
  endtask

  task automatic wait_valid;
    int n;
    n = 0;
    #1;
    while (!o_valid) begin
      if (n == TIMEOUT) fail_timeout("o_valid");
      n++;
      @(negedge i_clock);
      #1;
    end
  endtask

  task automatic check_row(input int idx, input logic [31:0] redirect);
    row_t r;
    r = rows[idx];
    check_value("o_valid", 32'(o_valid), 32'h1);
    check_value("o_reg_wen", 32'(o_reg_wen), r.reg_wen);
    if (r.reg_wen[0]) check_value("o_result", o_result, r.result);
    if (r.reg_wen[0]) check_value("o_rd", 32'(o_rd), 32'(r.instr[11:7]));
    check_value("o_jump", 32'(o_jump), r.jump);
    check_value("o_redirect", 32'(o_redirect), redirect);
    if (r.jump[0]) check_value("o_target", o_target, r.target);
    check_value("o_mem_ren", 32'(o_mem_ren), r.ren);
    check_value("o_mem_wen", 32'(o_mem_wen), r.wen);
    check_value("o_mem_wmask", 32'(o_mem_wmask), r.wmask);
    check_value("o_mem_read_t", 32'(o_mem_read_t), r.ren[0] ? 32'(r.instr[14:12]) : 32'h0);
    if (r.ren[0] || r.wen[0]) check_value("o_mem_addr", o_mem_addr, r.addr);
    check_value("o_mem_wdata", o_mem_wdata, r.rs2);
    check_value("o_exception", 32'(o_exception), r.exc);
    check_value("o_mcause", 32'(o_mcause), r.cause);
    check_value("o_csr_t", 32'(o_csr_t), r.csr_t);
    if (r.csr_t != 32'h0) check_value("o_csr_addr", 32'(o_csr_addr), 32'(r.instr[31:20]));
    check_value("o_fencei", 32'(o_fencei), 32'h0);
  endtask

  initial begin
    int n;
    void'($urandom(32'h567e1e2e));
    {i_valid, i_flush} = 2'b00;
    i_ready = 1'b1;
    {i_instr, i_pc, i_rs1_data, i_rs2_data, i_csr_data, i_trap_pc} = '0;
    build_table();
    n = 0;
    do begin
      if (n == TIMEOUT) fail_timeout("reset release");
      n++;
      @(negedge i_clock);
    end while (i_reset);
    #1;
    check_value("o_valid", 32'(o_valid), 32'h0);
    check_value("o_ready", 32'(o_ready), 32'h1);
    check_value("o_redirect", 32'(o_redirect), 32'h0);

    for (int i = 0; i < rows.size(); i++) begin
      issue_row(i);
      wait_valid();
      check_row(i, rows[i].jump);
      @(negedge i_clock);
      #1;
      check_value("o_valid", 32'(o_valid), 32'h0); // One item out per row
      check_value("o_redirect", 32'(o_redirect), 32'h0);
    end

    // Hold a jump in execute and a plain add behind it in decode
    @(negedge i_clock);
    i_ready = 1'b0;
    issue_row(24);
    issue_row(0);
    n = 0;
    #1;
    while (o_ready) begin
      if (n == TIMEOUT) fail_timeout("o_ready to drop under back-pressure");
      n++;
      @(negedge i_clock);
      #1;
    end
    wait_valid();
    held_result = o_result;
    held_target = o_target;
    held_addr   = o_mem_addr;
    repeat (4) begin
      @(negedge i_clock);
      #1;
      check_value("o_valid", 32'(o_valid), 32'h1);
      check_value("o_ready", 32'(o_ready), 32'h0);
      check_value("o_redirect", 32'(o_redirect), 32'h0);
      check_value("o_result", o_result, held_result);
      check_value("o_target", o_target, held_target);
      check_value("o_mem_addr", o_mem_addr, held_addr);
    end
    check_row(24, 32'h0);
    @(negedge i_clock);
    i_ready = 1'b1;
    @(negedge i_clock);
    #1;
    check_row(0, 32'h0);
    @(negedge i_clock);
    #1;
    check_value("o_valid", 32'(o_valid), 32'h0);

    // Flush two items in flight
    i_ready = 1'b0;
    issue_row(1);
    issue_row(2);
    @(negedge i_clock);
    i_flush = 1'b1;
    @(negedge i_clock);
    i_flush = 1'b0;
    i_ready = 1'b1;
    repeat (4) begin
      @(negedge i_clock);
      #1;
      check_value("o_valid", 32'(o_valid), 32'h0);
    end
    issue_row(3);
    wait_valid();
    check_row(3, rows[3].jump);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic o_clock,
  output logic o_reset
);

  initial begin
    o_clock = 1'b0;
    forever #4 o_clock = !o_clock; // 8 ns period
  end

  initial begin
    o_reset = 1'b1;
    repeat (10) @(posedge o_clock);
    @(negedge o_clock);
    o_reset = 1'b0;
  end

endmodule

// ==== verilog.f ====
verilog/rv_pkg.sv
verilog/exec_if.sv
verilog/alu.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/exec_top.sv
tb/tb_clock.sv
tb/exec_tb.sv

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic [rv_pkg::XLEN-1:0]     i_a,
  input  logic [rv_pkg::XLEN-1:0]     i_b,
  input  logic [rv_pkg::ALU_OP_W-1:0] i_op,
  input  logic                        i_sub,
  input  logic                        i_sign,
  output logic [rv_pkg::XLEN-1:0]     o_result,
  output logic                        o_cmp,
  output logic                        o_zero,
  output logic [rv_pkg::XLEN-1:0]     o_addr
);
  import rv_pkg::*;

  logic [XLEN-1:0] sum;
  logic [XLEN:0]   diff;
  logic [4:0]      shamt;

  assign sum   = i_sub ? (i_a - i_b) : (i_a + i_b);
  assign shamt = i_b[4:0];

  // One extra bit makes the borrow the less-than flag, signed or not
  assign diff   = {i_sign & i_a[XLEN-1], i_a} - {i_sign & i_b[XLEN-1], i_b};
  assign o_cmp  = diff[XLEN];
  assign o_zero = (i_a == i_b);

  assign o_addr = i_a + i_b; // Address path stays an add even when sub is set

  always_comb begin
    case (i_op)
      ALU_ADD:   o_result = sum;
      ALU_SLL:   o_result = i_a << shamt;
      ALU_SLT:   o_result = {{(XLEN-1){1'b0}}, o_cmp};
      ALU_PASSB: o_result = i_b;
      ALU_XOR:   o_result = i_a ^ i_b;
      ALU_SR: begin
        if (i_sign) begin
          o_result = $signed(i_a) >>> shamt;
        end else begin
          o_result = i_a >> shamt;
        end
      end
      ALU_OR:    o_result = i_a | i_b;
      ALU_AND:   o_result = i_a & i_b;
    endcase
  end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  rv_pkg::rv_instr_u       i_instr,
  input  logic [rv_pkg::XLEN-1:0] i_pc,
  input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
  input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
  input  logic [rv_pkg::XLEN-1:0] i_csr_data,
  input  logic [rv_pkg::XLEN-1:0] i_trap_pc,
  input  logic                    i_flush,
  output logic                    o_ready,
  exec_if.producer                o_exec
);
  import rv_pkg::*;

  logic [6:0]          opcode;
  logic [2:0]          func;
  logic                alt;
  logic [XLEN-1:0]     imm;
  logic [XLEN-1:0]     alu_a;
  logic [XLEN-1:0]     alu_b;
  logic [ALU_OP_W-1:0] alu_op;
  logic                alu_sub;
  logic                alu_sign;
  logic [4:0]          rd;
  logic [XLEN-1:0]     target_base;
  logic [1:0]          csr_t;
  logic                exception;
  logic [CAUSE_W-1:0]  mcause;
  logic                accept;

  function automatic logic [ALU_OP_W-1:0] func_to_alu(input logic [2:0] f);
    return (f == 3'b011) ? ALU_SLT : ALU_OP_W'(f); // Sltu is slt with the sign flag low
  endfunction

  assign opcode = i_instr.r_fmt.opcode;
  assign func   = i_instr.r_fmt.funct3;
  assign alt    = i_instr.r_fmt.funct7[5]; // Sub and sra select, also set in srai

  always_comb begin
    case (opcode)
      OP_STORE:
        imm = {{20{i_instr.s_fmt.imm_hi[6]}}, i_instr.s_fmt.imm_hi, i_instr.s_fmt.imm_lo};
      OP_BRANCH:
        imm = {{19{i_instr.b_fmt.imm_12}}, i_instr.b_fmt.imm_12, i_instr.b_fmt.imm_11,
               i_instr.b_fmt.imm_10_5, i_instr.b_fmt.imm_4_1, 1'b0};
      OP_LUI, OP_AUIPC:
        imm = {i_instr.u_fmt.imm, 12'b0};
      OP_JAL:
        imm = {{11{i_instr.j_fmt.imm_20}}, i_instr.j_fmt.imm_20, i_instr.j_fmt.imm_19_12,
               i_instr.j_fmt.imm_11, i_instr.j_fmt.imm_10_1, 1'b0};
      default:
        imm = {{20{i_instr.i_fmt.imm[11]}}, i_instr.i_fmt.imm};
    endcase
  end

  always_comb begin
    alu_a       = i_rs1_data;
    alu_b       = imm;
    alu_op      = ALU_ADD;
    alu_sub     = 1'b0;
    alu_sign    = 1'b0;
    rd          = i_instr.r_fmt.rd;
    target_base = i_pc;
    csr_t       = CSR_NONE;
    exception   = 1'b0;
    mcause      = '0;
    case (opcode)
      OP_REG: begin
        alu_b    = i_rs2_data;
        alu_op   = func_to_alu(func);
        alu_sub  = alt && (func == 3'b000);
        alu_sign = (func == 3'b101) ? alt : (func == 3'b010);
      end
      OP_IMM: begin
        alu_op   = func_to_alu(func);
        alu_sign = (func == 3'b101) ? alt : (func == 3'b010);
      end
      OP_LOAD, OP_FENCE: ; // Defaults give rs1 plus imm
      OP_STORE: rd = '0;
      OP_BRANCH: begin
        alu_b    = i_rs2_data;
        alu_sub  = 1'b1;
        alu_sign = !func[1]; // Bltu and bgeu compare unsigned
        rd       = '0;
      end
      OP_LUI: alu_op = ALU_PASSB;
      OP_AUIPC: alu_a = i_pc;
      OP_JAL, OP_JALR: begin
        alu_a = i_pc;
        alu_b = XLEN'(4);
        if (opcode == OP_JALR) begin
          target_base = i_rs1_data;
        end
      end
      OP_SYSTEM: begin
        alu_b  = i_csr_data;
        alu_op = ALU_PASSB;
        if (func == 3'b000) begin
          csr_t       = CSR_TRAP;
          target_base = i_trap_pc;
          if (i_instr.i_fmt.imm == 12'h000) begin
            exception = 1'b1;
            mcause    = CAUSE_ECALL;
          end else if (i_instr.i_fmt.imm != 12'h302) begin
            exception = 1'b1; // Only ecall and mret are supported here
            mcause    = CAUSE_ILLEGAL;
          end
        end else begin
          csr_t = CSR_WRITE;
        end
      end
      default: begin
        exception = 1'b1;
        mcause    = CAUSE_ILLEGAL;
        rd        = '0;
      end
    endcase
  end

  assign o_ready = !o_exec.valid || o_exec.ready;
  assign accept  = i_valid && o_ready && !i_flush;

  always_ff @(posedge i_clock) begin
    if (i_reset || i_flush) begin
      o_exec.valid <= 1'b0;
    end else if (accept) begin
      o_exec.valid <= 1'b1;
    end else if (o_exec.ready) begin
      o_exec.valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clock) begin
    if (accept) begin
      o_exec.op          <= opcode;
      o_exec.func        <= func;
      o_exec.alu_a       <= alu_a;
      o_exec.alu_b       <= alu_b;
      o_exec.alu_op      <= alu_op;
      o_exec.alu_sub     <= alu_sub;
      o_exec.alu_sign    <= alu_sign;
      o_exec.rd          <= rd;
      o_exec.rs2_data    <= i_rs2_data;
      o_exec.imm         <= imm;
      o_exec.pc          <= i_pc;
      o_exec.target_base <= target_base;
      o_exec.csr_t       <= csr_t;
      o_exec.csr_addr    <= i_instr.i_fmt.imm;
      o_exec.exception   <= exception;
      o_exec.mcause      <= mcause;
    end
  end

  a_hold_stable: assert property (@(posedge i_clock) disable iff (i_reset)
    o_exec.valid && !o_exec.ready && !i_flush |=> o_exec.valid &&
      $stable({o_exec.op, o_exec.alu_a, o_exec.alu_b, o_exec.imm, o_exec.rd,
               o_exec.target_base, o_exec.exception}));

endmodule

// ==== verilog/exec_if.sv ====
`timescale 1ns/1ps

interface exec_if;
  import rv_pkg::*;

  logic                valid;
  logic                ready;
  logic [6:0]          op;
  logic [2:0]          func;
  logic [XLEN-1:0]     alu_a;
  logic [XLEN-1:0]     alu_b;
  logic [ALU_OP_W-1:0] alu_op;
  logic                alu_sub;
  logic                alu_sign;
  logic [4:0]          rd;
  logic [XLEN-1:0]     rs2_data;
  logic [XLEN-1:0]     imm;
  logic [XLEN-1:0]     pc;
  logic [XLEN-1:0]     target_base; // Base of the jump target, imm is added in execute
  logic [1:0]          csr_t;
  logic [11:0]         csr_addr;
  logic                exception;
  logic [CAUSE_W-1:0]  mcause;

  modport producer (
    output valid, op, func, alu_a, alu_b, alu_op, alu_sub, alu_sign, rd,
    output rs2_data, imm, pc, target_base, csr_t, csr_addr, exception, mcause,
    input  ready
  );

  modport consumer (
    input  valid, op, func, alu_a, alu_b, alu_op, alu_sub, alu_sign, rd,
    input  rs2_data, imm, pc, target_base, csr_t, csr_addr, exception, mcause,
    output ready
  );

endinterface

// ==== verilog/exec_top.sv ====
`timescale 1ns/1ps

module exec_top (
  input  logic                       i_clock,
  input  logic                       i_reset,
  input  logic                       i_valid,
  input  logic [rv_pkg::XLEN-1:0]    i_instr,
  input  logic [rv_pkg::XLEN-1:0]    i_pc,
  input  logic [rv_pkg::XLEN-1:0]    i_rs1_data,
  input  logic [rv_pkg::XLEN-1:0]    i_rs2_data,
  input  logic [rv_pkg::XLEN-1:0]    i_csr_data,
  input  logic [rv_pkg::XLEN-1:0]    i_trap_pc,
  input  logic                       i_ready,
  input  logic                       i_flush,
  output logic                       o_ready,
  output logic                       o_valid,
  output logic [rv_pkg::XLEN-1:0]    o_result,
  output logic                       o_reg_wen,
  output logic [4:0]                 o_rd,
  output logic                       o_jump,
  output logic                       o_redirect,
  output logic [rv_pkg::XLEN-1:0]    o_target,
  output logic                       o_mem_ren,
  output logic                       o_mem_wen,
  output logic [3:0]                 o_mem_wmask,
  output logic [2:0]                 o_mem_read_t,
  output logic [rv_pkg::XLEN-1:0]    o_mem_addr,
  output logic [rv_pkg::XLEN-1:0]    o_mem_wdata,
  output logic                       o_fencei,
  output logic [1:0]                 o_csr_t,
  output logic [11:0]                o_csr_addr,
  output logic                       o_exception,
  output logic [rv_pkg::CAUSE_W-1:0] o_mcause
);

  exec_if exec_bus ();

  decode_stage u_decode (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_valid    (i_valid),
    .i_instr    (i_instr),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .i_csr_data (i_csr_data),
    .i_trap_pc  (i_trap_pc),
    .i_flush    (i_flush),
    .o_ready    (o_ready),
    .o_exec     (exec_bus.producer)
  );

  execute_stage u_execute (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_ready      (i_ready),
    .i_flush      (i_flush),
    .i_exec       (exec_bus.consumer),
    .o_valid      (o_valid),
    .o_result     (o_result),
    .o_reg_wen    (o_reg_wen),
    .o_rd         (o_rd),
    .o_jump       (o_jump),
    .o_redirect   (o_redirect),
    .o_target     (o_target),
    .o_mem_ren    (o_mem_ren),
    .o_mem_wen    (o_mem_wen),
    .o_mem_wmask  (o_mem_wmask),
    .o_mem_read_t (o_mem_read_t),
    .o_mem_addr   (o_mem_addr),
    .o_mem_wdata  (o_mem_wdata),
    .o_fencei     (o_fencei),
    .o_csr_t      (o_csr_t),
    .o_csr_addr   (o_csr_addr),
    .o_exception  (o_exception),
    .o_mcause     (o_mcause)
  );

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                         i_clock,
  input  logic                         i_reset,
  input  logic                         i_ready,
  input  logic                         i_flush,
  exec_if.consumer                     i_exec,
  output logic                         o_valid,
  output logic [rv_pkg::XLEN-1:0]      o_result,
  output logic                         o_reg_wen,
  output logic [4:0]                   o_rd,
  output logic                         o_jump,
  output logic                         o_redirect,
  output logic [rv_pkg::XLEN-1:0]      o_target,
  output logic                         o_mem_ren,
  output logic                         o_mem_wen,
  output logic [3:0]                   o_mem_wmask,
  output logic [2:0]                   o_mem_read_t,
  output logic [rv_pkg::XLEN-1:0]      o_mem_addr,
  output logic [rv_pkg::XLEN-1:0]      o_mem_wdata,
  output logic                         o_fencei,
  output logic [1:0]                   o_csr_t,
  output logic [11:0]                  o_csr_addr,
  output logic                         o_exception,
  output logic [rv_pkg::CAUSE_W-1:0]   o_mcause
);
  import rv_pkg::*;

  logic [6:0]          op;
  logic [2:0]          func;
  logic [XLEN-1:0]     alu_a;
  logic [XLEN-1:0]     alu_b;
  logic [ALU_OP_W-1:0] alu_op;
  logic                alu_sub;
  logic                alu_sign;
  logic [XLEN-1:0]     rs2_data;
  logic [XLEN-1:0]     imm;
  logic [XLEN-1:0]     target_base;
  logic [XLEN-1:0]     jump_sum;
  logic                accept;
  logic                fresh;
  logic                cmp;
  logic                zero;
  logic                taken;
  logic                is_branch;
  logic                is_jalr;
  logic                is_trap;

  assign i_exec.ready = !o_valid || i_ready;
  assign accept       = i_exec.valid && i_exec.ready && !i_flush;

  always_ff @(posedge i_clock) begin
    if (i_reset || i_flush) begin
      o_valid <= 1'b0;
    end else if (accept) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      fresh <= 1'b0;
    end else begin
      fresh <= accept; // High only in the first cycle an item is presented
    end
  end

  always_ff @(posedge i_clock) begin
    if (accept) begin
      op          <= i_exec.op;
      func        <= i_exec.func;
      alu_a       <= i_exec.alu_a;
      alu_b       <= i_exec.alu_b;
      alu_op      <= i_exec.alu_op;
      alu_sub     <= i_exec.alu_sub;
      alu_sign    <= i_exec.alu_sign;
      o_rd        <= i_exec.rd;
      rs2_data    <= i_exec.rs2_data;
      imm         <= i_exec.imm;
      target_base <= i_exec.target_base;
      o_csr_t     <= i_exec.csr_t;
      o_csr_addr  <= i_exec.csr_addr;
      o_exception <= i_exec.exception;
      o_mcause    <= i_exec.mcause;
    end
  end

  alu u_alu (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_op     (alu_op),
    .i_sub    (alu_sub),
    .i_sign   (alu_sign),
    .o_result (o_result),
    .o_cmp    (cmp),
    .o_zero   (zero),
    .o_addr   (o_mem_addr)
  );

  assign is_branch = (op == OP_BRANCH);
  assign is_jalr   = (op == OP_JALR);
  assign is_trap   = (o_csr_t == CSR_TRAP);

  always_comb begin
    case (func)
      3'b000:         taken = zero;
      3'b001:         taken = !zero;
      3'b100, 3'b110: taken = cmp;
      3'b101, 3'b111: taken = !cmp;
      default:        taken = 1'b0;
    endcase
  end

  assign o_jump     = (op == OP_JAL) || is_jalr || (is_branch && taken) || is_trap;
  assign o_redirect = o_valid && fresh && o_jump;

  assign jump_sum = target_base + imm;
  assign o_target = is_trap ? target_base :
                    is_jalr ? {jump_sum[XLEN-1:1], 1'b0} : jump_sum;

  assign o_mem_ren    = (op == OP_LOAD);
  assign o_mem_wen    = (op == OP_STORE);
  assign o_mem_wmask  = !o_mem_wen ? 4'b0000 :
                        (func[1:0] == 2'b00) ? 4'b0001 :
                        (func[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
  assign o_mem_read_t = o_mem_ren ? func : 3'b000; // Size and sign of the load
  assign o_mem_wdata  = rs2_data;

  assign o_reg_wen = !(o_mem_wen || is_branch || o_exception);
  assign o_fencei  = (op == OP_FENCE) && (func == 3'b001);

  a_mem_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
    !(o_valid && o_mem_ren && o_mem_wen));

  // A redirect belongs to a valid item and never repeats while it waits
  a_redirect_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
    o_redirect |-> o_valid ##1 (!o_redirect || $past(i_ready)));

  a_target_base: assert property (@(posedge i_clock) disable iff (i_reset)
    i_exec.valid && (i_exec.op == OP_JAL || i_exec.op == OP_BRANCH)
      |-> i_exec.target_base == i_exec.pc);

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN = 32;

  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;

  // Codes follow funct3 so register and immediate ops map straight across
  localparam int ALU_OP_W = 3;
  localparam logic [ALU_OP_W-1:0] ALU_ADD   = 3'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SLL   = 3'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLT   = 3'd2;
  localparam logic [ALU_OP_W-1:0] ALU_PASSB = 3'd3; // Slot of sltu, which reuses ALU_SLT
  localparam logic [ALU_OP_W-1:0] ALU_XOR   = 3'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SR    = 3'd5;
  localparam logic [ALU_OP_W-1:0] ALU_OR    = 3'd6;
  localparam logic [ALU_OP_W-1:0] ALU_AND   = 3'd7;

  localparam int CAUSE_W = 4;
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL = 4'd2;
  localparam logic [CAUSE_W-1:0] CAUSE_ECALL   = 4'd11;

  localparam logic [1:0] CSR_NONE  = 2'd0;
  localparam logic [1:0] CSR_WRITE = 2'd1;
  localparam logic [1:0] CSR_TRAP  = 2'd2; // Ecall and mret, both redirect

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } rv_instr_u;

endpackage
